// ==== source/busint.sv ====
/*
 * Bus controller top level. Arbitrates between the processor port and
 * the DMA engine, steers the memory port to the bus owner, and ends
 * unanswered processor accesses with a timeout.
 */
module busint
(
   input  logic                        mclk,
   input  logic                        reset,
   input  logic [xbus_pkg::ADDR_W-1:0] addr,
   input  logic [xbus_pkg::DATA_W-1:0] busin,
   input  logic                        req,
   input  logic                        write,
   output logic [xbus_pkg::DATA_W-1:0] busout,
   output logic                        ack,
   output logic                        load,
   output logic                        interrupt,
   output xbus_pkg::bus_state_t        bus_state
);

   import xbus_pkg::*;

   bus_state_t state;
   bus_state_t next_state;

   logic [$bits(TIMEOUT_MAX)-1:0] timeout_count;
   logic timed_out;

   logic req_valid;
   logic grant;
   logic device_ack;
   logic read_active;

   logic [ADDR_W-1:0] ram_addr;
   logic [DATA_W-1:0] ram_datain;
   logic [DATA_W-1:0] dataout_ram;
   logic ram_req;
   logic ram_write;
   logic ack_ram;
   logic decode_ram;

   logic [DATA_W-1:0] dataout_dma;
   logic ack_dma;
   logic decode_dma;
   logic irq_dma;
   logic dma_busreq;
   logic [ADDR_W-1:0] dma_addrout;
   logic dma_reqout;
   logic dma_writeout;
   logic [DATA_W-1:0] dma_data_m;

   assign req_valid = req && (state == bus_req);
   assign grant = (state == bus_slave);

   // Memory follows whoever owns the bus.
   assign ram_addr = grant ? dma_addrout : addr;
   assign ram_datain = grant ? dma_data_m : busin;
   assign ram_req = grant ? dma_reqout : req_valid;
   assign ram_write = grant ? dma_writeout : (write && req_valid);

   xbus_ram ram0
   (
      .mclk    (mclk),
      .reset   (reset),
      .addr    (ram_addr),
      .datain  (ram_datain),
      .req     (ram_req),
      .write   (ram_write),
      .dataout (dataout_ram),
      .ack     (ack_ram),
      .decode  (decode_ram)
   );

   xbus_dma dma0
   (
      .mclk      (mclk),
      .reset     (reset),
      .addr      (addr),
      .datain    (busin),
      .req       (req_valid),
      .write     (write),
      .dataout   (dataout_dma),
      .ack       (ack_dma),
      .decode    (decode_dma),
      .interrupt (irq_dma),
      .busreq    (dma_busreq),
      .busgrant  (grant),
      .addrout   (dma_addrout),
      .reqout    (dma_reqout),
      .writeout  (dma_writeout),
      .dataout_m (dma_data_m),
      .ackin     (grant && ack_ram),
      .datain_m  (dataout_ram)
   );

   assign device_ack = ack_ram || ack_dma || timed_out;

   // Processor wins a tie in bus_idle.
   always_comb
   begin
      next_state = state;
      unique case (state)
         bus_idle:
         begin
            if (req)
               next_state = bus_req;
            else if (dma_busreq)
               next_state = bus_slave;
         end
         bus_req:   if (device_ack) next_state = bus_wait;
         bus_wait:  if (!req) next_state = bus_idle;
         bus_slave: if (!dma_busreq) next_state = bus_swait;
         bus_swait: next_state = bus_idle;
         default:   next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         state <= bus_idle;
      else
         state <= next_state;
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         timeout_count <= '0;
      else if (state == bus_req && !timed_out)
         timeout_count <= timeout_count + 1'b1;
      else if (state == bus_wait)
         timeout_count <= '0;
   end

   assign timed_out = (timeout_count == TIMEOUT_MAX);

   assign ack = (device_ack && state == bus_req) || (state == bus_wait);
   assign load = device_ack && !write && (state == bus_req);

   // Unmapped reads return zero; idle bus reads all ones.
   assign read_active = req && !write && (state == bus_req || state == bus_wait);
   assign busout = !read_active ? '1 :
                   decode_ram   ? dataout_ram :
                   decode_dma   ? dataout_dma :
                   '0;

   assign interrupt = irq_dma;
   assign bus_state = state;

endmodule

// ==== source/xbus_dma.sv ====
/*
 * Block-copy DMA engine. As a slave it exposes source, destination,
 * count and status registers; writing the count starts a copy, which
 * it runs as a bus master one read and one write per word.
 */
module xbus_dma
(
   input  logic                        mclk,
   input  logic                        reset,
   input  logic [xbus_pkg::ADDR_W-1:0] addr,
   input  logic [xbus_pkg::DATA_W-1:0] datain,
   input  logic                        req,
   input  logic                        write,
   output logic [xbus_pkg::DATA_W-1:0] dataout,
   output logic                        ack,
   output logic                        decode,
   output logic                        interrupt,
   output logic                        busreq,
   input  logic                        busgrant,
   output logic [xbus_pkg::ADDR_W-1:0] addrout,
   output logic                        reqout,
   output logic                        writeout,
   output logic [xbus_pkg::DATA_W-1:0] dataout_m,
   input  logic                        ackin,
   input  logic [xbus_pkg::DATA_W-1:0] datain_m
);

   import xbus_pkg::*;

   typedef enum logic [2:0] {
      dma_idle,
      dma_rd,
      dma_rd_end,
      dma_wr,
      dma_wr_end
   } dma_state_t;

   dma_state_t state;
   logic [ADDR_W-1:0] src;
   logic [ADDR_W-1:0] dst;
   logic [ADDR_W-1:0] cnt;
   logic [DATA_W-1:0] word;
   logic done;
   logic busy;
   logic hit;

   assign decode = (addr[ADDR_W-1:2] == DMA_BASE[ADDR_W-1:2]);
   assign hit = req && decode;
   assign busy = (state != dma_idle);
   assign busreq = busy;
   assign interrupt = done;

   // Source on reads, destination on writes.
   assign addrout = (state == dma_wr) ? dst : src;
   assign reqout = busgrant && (state == dma_rd || state == dma_wr);
   assign writeout = busgrant && (state == dma_wr);
   assign dataout_m = word;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         state <= dma_idle;
         src <= '0;
         dst <= '0;
         cnt <= '0;
         done <= 1'b0;
         ack <= 1'b0;
      end
      else
      begin
         ack <= hit;

         // Register writes; setup registers are locked during a copy.
         if (hit && write && !ack)
         begin
            unique case (addr[1:0])
               DMA_SRC: if (!busy) src <= datain[ADDR_W-1:0];
               DMA_DST: if (!busy) dst <= datain[ADDR_W-1:0];
               DMA_CNT:
               begin
                  if (!busy)
                  begin
                     cnt <= datain[ADDR_W-1:0];
                     if (datain[ADDR_W-1:0] == '0)
                        done <= 1'b1;
                     else
                        state <= dma_rd;
                  end
               end
               DMA_STAT: done <= 1'b0;
            endcase
         end

         // The gap states drop reqout so the memory restarts its wait.
         unique case (state)
            dma_rd:
            begin
               if (ackin)
               begin
                  src <= src + 1'b1;
                  state <= dma_rd_end;
               end
            end
            dma_rd_end: state <= dma_wr;
            dma_wr:
            begin
               if (ackin)
               begin
                  dst <= dst + 1'b1;
                  cnt <= cnt - 1'b1;
                  if (cnt == ADDR_W'(1))
                  begin
                     state <= dma_idle;
                     done <= 1'b1;
                  end
                  else
                  begin
                     state <= dma_wr_end;
                  end
               end
            end
            dma_wr_end: state <= dma_rd;
            default: ;
         endcase
      end
   end

   always_ff @(posedge mclk)
   begin
      if (state == dma_rd && ackin)
      begin
         word <= datain_m;
      end

      if (hit && !write && !ack)
      begin
         unique case (addr[1:0])
            DMA_SRC:  dataout <= DATA_W'(src);
            DMA_DST:  dataout <= DATA_W'(dst);
            DMA_CNT:  dataout <= DATA_W'(cnt);
            DMA_STAT: dataout <= DATA_W'({done, busy});
         endcase
      end
   end

endmodule

// ==== source/xbus_pkg.sv ====
/*
 * Shared definitions for the bus subsystem: bus widths, the address map,
 * memory wait and bus timeout constants, and the controller state type.
 * Each module imports this package inside its body.
 */
package xbus_pkg;

   localparam int ADDR_W = 22;
   localparam int DATA_W = 32;

   // Memory answers the low 1024 words.
   localparam int RAM_AW = 10;
   localparam int RAM_WAIT = 2;
   localparam int RAM_WAIT_W = $clog2(RAM_WAIT + 1);

   // DMA register block, four words, aligned.
   localparam logic [ADDR_W-1:0] DMA_BASE = 22'h10_0000;
   localparam logic [1:0] DMA_SRC = 2'd0;
   localparam logic [1:0] DMA_DST = 2'd1;
   localparam logic [1:0] DMA_CNT = 2'd2;
   localparam logic [1:0] DMA_STAT = 2'd3;

   // Cycles in bus_req before an unanswered access is ended.
   localparam logic [5:0] TIMEOUT_MAX = 6'd63;

   typedef enum logic [3:0] {
      bus_idle  = 4'b0000,
      bus_req   = 4'b0001,
      bus_wait  = 4'b0010,
      bus_slave = 4'b0100,
      bus_swait = 4'b1000
   } bus_state_t;

endpackage

// ==== source/xbus_ram.sv ====
/*
 * Word memory bus slave. A request must be held for RAM_WAIT cycles
 * before the access is done; ack then stays high until req drops.
 */
module xbus_ram
(
   input  logic                        mclk,
   input  logic                        reset,
   input  logic [xbus_pkg::ADDR_W-1:0] addr,
   input  logic [xbus_pkg::DATA_W-1:0] datain,
   input  logic                        req,
   input  logic                        write,
   output logic [xbus_pkg::DATA_W-1:0] dataout,
   output logic                        ack,
   output logic                        decode
);

   import xbus_pkg::*;

   logic [DATA_W-1:0] mem [0:(1 << RAM_AW)-1];
   logic [RAM_WAIT_W-1:0] wait_cnt;
   logic hit;
   logic wait_done;

   // Everything with zero upper bits lands here.
   assign decode = (addr[ADDR_W-1:RAM_AW] == '0);
   assign hit = req && decode;
   assign wait_done = (wait_cnt == RAM_WAIT_W'(RAM_WAIT));

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         wait_cnt <= '0;
         ack <= 1'b0;
      end
      else
      begin
         if (!hit)
         begin
            wait_cnt <= '0;
         end
         else if (!wait_done)
         begin
            wait_cnt <= wait_cnt + 1'b1;
         end

         // Held until the master lets go of req.
         ack <= hit && (ack || wait_done);
      end
   end

   // Single access per request, on the cycle before ack rises.
   always_ff @(posedge mclk)
   begin
      if (hit && wait_done && !ack)
      begin
         if (write)
         begin
            mem[addr[RAM_AW-1:0]] <= datain;
         end
         else
         begin
            dataout <= mem[addr[RAM_AW-1:0]];
         end
      end
   end

endmodule

// ==== tb/bus_master.sv ====
/*
 * Processor-side bus model for the busint testbench. Each task expects
 * to be called 1 ns after a rising edge, drives the request there, and
 * returns 1 ns after the edge where ack is seen low again.
 */
module bus_master
(
   input  logic                        mclk,
   input  logic                        ack,
   input  logic                        load,
   input  logic [xbus_pkg::DATA_W-1:0] busout,
   output logic                        req,
   output logic [xbus_pkg::ADDR_W-1:0] addr,
   output logic                        write,
   output logic [xbus_pkg::DATA_W-1:0] busin
);

   timeunit 1ns;
   timeprecision 100ps;

   import xbus_pkg::*;

   initial
   begin
      req = 1'b0;
      addr = '0;
      write = 1'b0;
      busin = '0;
   end

   task automatic wait_ack();
      @(posedge mclk);
      #1;
      while (!ack)
      begin
         @(posedge mclk);
         #1;
      end
   endtask

   // Write stays put until ack is gone, so no stray load on a write.
   task automatic end_access();
      req = 1'b0;
      while (ack)
      begin
         @(posedge mclk);
         #1;
      end
      write = 1'b0;
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      addr = a;
      busin = d;
      write = 1'b1;
      req = 1'b1;
      wait_ack();
      end_access();
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d,
                            output logic loaded);
      addr = a;
      write = 1'b0;
      req = 1'b1;
      wait_ack();
      loaded = load;
      d = busout;
      end_access();
   endtask

endmodule

// ==== tb/tb_busint.sv ====
/*
 * Testbench for the bus controller. Drives the processor port through
 * memory, timeout, DMA register, DMA copy and back-pressure accesses;
 * assertions compare the port against a reference memory.
 */
module tb_busint;

   timeunit 1ns;
   timeprecision 100ps;

   import xbus_pkg::*;

   localparam int CYCLE_LIMIT = 3000;
   localparam int RAND_WORDS = 8;
   localparam int COPY_LEN = 16;
   localparam logic [RAM_AW-1:0] SRC_WORD = 10'h100;
   localparam logic [RAM_AW-1:0] DST_WORD = 10'h300;

   logic mclk;
   logic reset;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] busin;
   logic req;
   logic write;
   logic [DATA_W-1:0] busout;
   logic ack;
   logic load;
   logic interrupt;
   bus_state_t bus_state;

   logic [DATA_W-1:0] ref_mem [0:(1 << RAM_AW)-1];
   logic [RAM_AW-1:0] used_addr [$];
   integer seed;
   int cycles;
   logic reset_q;
   logic bp_phase;

   busint dut0
   (
      .mclk      (mclk),
      .reset     (reset),
      .addr      (addr),
      .busin     (busin),
      .req       (req),
      .write     (write),
      .busout    (busout),
      .ack       (ack),
      .load      (load),
      .interrupt (interrupt),
      .bus_state (bus_state)
   );

   bus_master cpu
   (
      .mclk   (mclk),
      .ack    (ack),
      .load   (load),
      .busout (busout),
      .req    (req),
      .addr   (addr),
      .write  (write),
      .busin  (busin)
   );

   always #10 mclk = ~mclk;

   always @(posedge mclk)
   begin
      reset_q <= reset;
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         stop_failed();
      end
   end

   task automatic stop_failed();
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic report_error(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      stop_failed();
   endtask

   reset_quiet: assert property (@(posedge mclk)
      reset_q |-> (!ack && !load && !interrupt && bus_state == bus_idle))
      else report_error("outputs active during reset");

   load_with_ack: assert property (@(posedge mclk) load |-> ack)
      else report_error("load high without ack");

   load_one_cycle: assert property (@(posedge mclk) load |=> !load)
      else report_error("load high for more than one cycle");

   idle_ones: assert property (@(posedge mclk) (!req || write) |-> busout == '1)
      else report_error("busout not all ones with no read in progress");

   // A held request must not finish before the copy has.
   held_by_copy: assert property (@(posedge mclk) (bp_phase && $rose(ack)) |-> interrupt)
      else report_error("back-pressured read acknowledged before copy end");

   task automatic store_word(input logic [RAM_AW-1:0] a, input logic [DATA_W-1:0] d);
      cpu.write_word(ADDR_W'(a), d);
      ref_mem[a] = d;
      used_addr.push_back(a);
   endtask

   task automatic check_word(input logic [RAM_AW-1:0] a);
      logic [DATA_W-1:0] d;
      logic loaded;
      cpu.read_word(ADDR_W'(a), d, loaded);
      assert (loaded)
         else report_error($sformatf("no load pulse on read of %h", a));
      assert (d === ref_mem[a])
         else report_error($sformatf("read %h at %h, expected %h", d, a, ref_mem[a]));
   endtask

   task automatic write_reg(input logic [1:0] ofs, input logic [DATA_W-1:0] d);
      cpu.write_word(DMA_BASE | ADDR_W'(ofs), d);
   endtask

   task automatic expect_reg(input logic [1:0] ofs, input logic [DATA_W-1:0] expected);
      logic [DATA_W-1:0] d;
      logic loaded;
      cpu.read_word(DMA_BASE | ADDR_W'(ofs), d, loaded);
      assert (loaded && d === expected)
         else report_error($sformatf("DMA reg %0d read %h, expected %h", ofs, d, expected));
   endtask

   task automatic expect_timeout_read(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] d;
      logic loaded;
      cpu.read_word(a, d, loaded);
      assert (loaded && d === '0)
         else report_error($sformatf("unmapped read of %h returned %h", a, d));
   endtask

   initial
   begin : stimulus
      logic [DATA_W-1:0] rnd;
      logic [RAM_AW-1:0] a;
      seed = 32'hd50c_18d1;
      mclk = 1'b0;
      reset = 1'b1;
      reset_q = 1'b0;
      bp_phase = 1'b0;
      cycles = 0;

      repeat (4) @(posedge mclk);
      #1;
      reset = 1'b0;
      @(posedge mclk);
      #1;
      assert (!ack && !load && !interrupt && bus_state == bus_idle)
         else report_error("outputs not idle after reset");

      // Random words to random addresses.
      for (int i = 0; i < RAND_WORDS; i++)
      begin
         rnd = $random(seed);
         a = rnd[RAM_AW-1:0];
         rnd = $random(seed);
         store_word(a, rnd);
      end
      foreach (used_addr[k])
         check_word(used_addr[k]);

      // Unmapped accesses end by timeout.
      expect_timeout_read(22'h20_0000);
      cpu.write_word(22'h20_0000 | ADDR_W'(used_addr[0]), 32'hdead_beef);
      expect_timeout_read(22'h3f_ffff);
      cpu.write_word(DMA_BASE + 22'd4, 32'h1234_5678);
      foreach (used_addr[k])
         check_word(used_addr[k]);

      for (int i = 0; i < COPY_LEN; i++)
      begin
         rnd = $random(seed);
         store_word(SRC_WORD + RAM_AW'(i), rnd);
      end

      write_reg(DMA_SRC, DATA_W'(SRC_WORD));
      write_reg(DMA_DST, DATA_W'(DST_WORD));
      expect_reg(DMA_SRC, DATA_W'(SRC_WORD));
      expect_reg(DMA_DST, DATA_W'(DST_WORD));

      // Back-to-back accesses keep the bus away from the engine.
      write_reg(DMA_CNT, COPY_LEN);
      expect_reg(DMA_CNT, COPY_LEN);
      expect_reg(DMA_STAT, 32'h1);

      repeat (2) @(posedge mclk);
      #1;
      assert (bus_state == bus_slave)
         else report_error("DMA engine did not take the bus");
      bp_phase = 1'b1;
      check_word(SRC_WORD);
      bp_phase = 1'b0;
      assert (interrupt)
         else report_error("no interrupt after the copy");

      for (int i = 0; i < COPY_LEN; i++)
      begin
         ref_mem[DST_WORD + RAM_AW'(i)] = ref_mem[SRC_WORD + RAM_AW'(i)];
      end
      expect_reg(DMA_STAT, 32'h2);
      for (int i = 0; i < COPY_LEN; i++)
         check_word(DST_WORD + RAM_AW'(i));

      write_reg(DMA_STAT, '0);
      assert (!interrupt)
         else report_error("status write did not clear the interrupt");

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
source/xbus_pkg.sv
source/xbus_ram.sv
source/xbus_dma.sv
source/busint.sv
tb/bus_master.sv
tb/tb_busint.sv
